/* project.f */
hw/uart_pkg.sv
hw/baud_timer.sv
hw/uart_tx_shift.sv
hw/uart_rx_shift.sv
hw/uart_ctrl_fsm.sv
hw/uart_cmd_top.sv
tests/tb_clk_gen.sv
tests/tb_uart_checker.sv
tests/tb_uart_cmd.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_uart_cmd -f project.f -o sim_uart_cmd

./obj_dir/sim_uart_cmd | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"

/* tests/tb_uart_cmd.sv */
`timescale 1ns/1ps

module tb_uart_cmd
  import uart_pkg::*;
();

  localparam int NUM_ROWS     = 10;
  localparam int RESET_CYCLES = 10;
  localparam int CYCLE_LIMIT  = RESET_CYCLES +
    NUM_ROWS * (3 * 11 + GAP_BITS + RESP_TIMEOUT_BITS + 4) * BAUD_DIV;

  localparam logic [1:0] MODE_NORMAL     = 2'd0;
  localparam logic [1:0] MODE_BAD_PARITY = 2'd1;
  localparam logic [1:0] MODE_SILENT     = 2'd2;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd_in;
  logic       cmd_vld;
  logic       rx;
  logic       tx;
  logic       cmd_rdy;
  logic       read_rdy;
  logic       read_err;
  byte_t      read_data;
  logic [1:0] resp_mode;
  byte_t      resp_byte;
  int         rows_done;
  int         rows_pass;
  int         rows_fail;
  int         check_errs;
  int         cycles;

  // each row holds a command, the responder mode and whether the data byte is random.
  cmd_t cmd_tab [NUM_ROWS] = '{16'h853C, 16'h0500, 16'h9200, 16'h1200, 16'h1200,
                               16'h3300, 16'hFF00, 16'h7F00, 16'h2A00, 16'hC0A5};
  logic [1:0] mode_tab [NUM_ROWS] = '{MODE_NORMAL, MODE_NORMAL, MODE_NORMAL, MODE_NORMAL,
                                      MODE_BAD_PARITY, MODE_SILENT, MODE_NORMAL,
                                      MODE_NORMAL, MODE_NORMAL, MODE_NORMAL};
  logic rand_tab [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

  tb_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .read_data (read_data)
  );

  tb_uart_checker i_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .tx         (tx),
    .read_rdy   (read_rdy),
    .read_err   (read_err),
    .read_data  (read_data),
    .resp_mode  (resp_mode),
    .resp_byte  (resp_byte),
    .rows_done  (rows_done),
    .rows_pass  (rows_pass),
    .rows_fail  (rows_fail),
    .check_errs (check_errs)
  );

  task automatic send_response(input byte_t value, input logic flip_parity);
    logic [10:0] frame;
    begin
      frame = {1'b1, (^value) ^ flip_parity, value, 1'b0};
      for (int b = 0; b < 11; b++)
      begin
        rx = frame[b];
        repeat (BAUD_DIV) @(negedge clk);
      end
    end
  endtask

  task automatic run_row(input int idx);
    @(negedge clk);
    resp_mode = mode_tab[idx];
    cmd_in    = cmd_tab[idx];
    cmd_vld   = 1'b1;
    while (!cmd_rdy)
      @(negedge clk);
    // cmd_vld stays high through the whole first frame while the DUT is busy.
    @(negedge clk);
    while (tx)
      @(negedge clk);
    repeat (11 * BAUD_DIV) @(negedge clk);
    cmd_vld = 1'b0;
    if (!cmd_tab[idx][15] && mode_tab[idx] != MODE_SILENT)
    begin
      repeat (2 * BAUD_DIV) @(negedge clk);
      send_response(resp_byte, mode_tab[idx] == MODE_BAD_PARITY);
    end
    while (rows_done < idx + 1)
      @(negedge clk);
  endtask

  initial
  begin
    void'($urandom(92));
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    resp_mode = MODE_NORMAL;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (rand_tab[i])
        cmd_tab[i][7:0] = 8'($urandom());
    end
    wait (rst_n === 1'b1);
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      run_row(i);
    end
    // a short idle tail catches a command that was taken twice.
    repeat (4 * BAUD_DIV) @(negedge clk);
    $display("rows passed %0d, rows failed %0d, failed checks %0d",
             rows_pass, rows_fail, check_errs);
    if (check_errs == 0 && rows_fail == 0 && rows_pass == NUM_ROWS)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* tests/tb_uart_checker.sv */
`timescale 1ns/1ps

module tb_uart_checker
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd_in,
  input  logic       cmd_vld,
  input  logic       cmd_rdy,
  input  logic       tx,
  input  logic       read_rdy,
  input  logic       read_err,
  input  byte_t      read_data,
  input  logic [1:0] resp_mode,
  output byte_t      resp_byte,
  output int         rows_done,
  output int         rows_pass,
  output int         rows_fail,
  output int         check_errs
);

  localparam logic [1:0] MODE_BAD_PARITY = 2'd1;
  localparam logic [1:0] MODE_SILENT     = 2'd2;

  byte_t      model [128];
  cmd_t       cur_cmd;
  logic [1:0] cur_mode;
  logic       row_busy;
  logic       row_ok;
  logic       reset_seen;
  byte_t      shown_data;
  int         row_idx;
  int         frames_seen;
  int         cyc;
  int         frame_end_cyc;

  // the responder answers reads with the model value of the open command's address.
  assign resp_byte = model[cur_cmd[14:8]];

  initial
  begin
    for (int i = 0; i < 128; i++)
    begin
      model[i] = 8'(i * 37 + 11);
    end
    cur_cmd       = '0;
    cur_mode      = '0;
    row_busy      = 1'b0;
    row_ok        = 1'b1;
    reset_seen    = 1'b0;
    shown_data    = '0;
    row_idx       = 0;
    frames_seen   = 0;
    cyc           = 0;
    frame_end_cyc = 0;
    rows_done     <= 0;
    rows_pass     = 0;
    rows_fail     = 0;
    check_errs    = 0;
  end

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    check_errs++;
    row_ok = 1'b0;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    check_errs++;
    row_ok = 1'b0;
  endtask

  task automatic close_row();
    string kind;
    begin
      if (cur_cmd[15])
        kind = "write";
      else if (cur_mode == MODE_SILENT)
        kind = "read with silent responder";
      else if (cur_mode == MODE_BAD_PARITY)
        kind = "read with bad parity";
      else
        kind = "read";
      if (row_ok)
        rows_pass++;
      else
        rows_fail++;
      $display("row %0d: %s addr %02h data %02h %s", row_idx, kind, cur_cmd[14:8],
               shown_data, row_ok ? "ok" : "failed");
      row_busy = 1'b0;
      row_idx++;
      rows_done <= rows_done + 1;
    end
  endtask

  task automatic check_rdy_low();
    if (cmd_rdy !== 1'b0)
      report_mismatch("cmd_rdy is high while a frame is on tx");
  endtask

  task automatic take_frame(input byte_t data, input logic par, input logic stop);
    byte_t expected;
    begin
      frame_end_cyc = cyc;
      frames_seen++;
      expected = (frames_seen == 1) ? cur_cmd[15:8] : cur_cmd[7:0];
      if (frames_seen > (cur_cmd[15] ? 2 : 1))
        report_problem("more frames on tx than the command calls for");
      else if (data !== expected)
        report_mismatch($sformatf("tx frame %0d is %02h, expected %02h",
                                  frames_seen, data, expected));
      if (par !== ^data)
        report_mismatch($sformatf("tx frame %02h has parity bit %b", data, par));
      if (stop !== 1'b1)
        report_mismatch($sformatf("tx frame %02h has a low stop bit", data));
      if (row_busy && cur_cmd[15] && frames_seen == 2)
      begin
        model[cur_cmd[14:8]] = cur_cmd[7:0];
        shown_data = cur_cmd[7:0];
        close_row();
      end
    end
  endtask

  // samples each bit of a tx frame near its middle.
  task automatic decode_frame();
    byte_t data;
    logic  par;
    logic  stop;
    begin
      if (!row_busy)
        report_problem("a frame started on tx with no command in progress");
      repeat (HALF_DIV) @(negedge clk);
      if (tx !== 1'b0)
        report_mismatch("tx start bit is not low at its middle");
      check_rdy_low();
      for (int b = 0; b < 8; b++)
      begin
        repeat (BAUD_DIV) @(negedge clk);
        data[b] = tx;
        check_rdy_low();
      end
      repeat (BAUD_DIV) @(negedge clk);
      par = tx;
      check_rdy_low();
      repeat (BAUD_DIV) @(negedge clk);
      stop = tx;
      check_rdy_low();
      take_frame(data, par, stop);
    end
  endtask

  task automatic check_read();
    if (!row_busy || cur_cmd[15])
    begin
      report_problem("read_rdy pulsed with no read command in progress");
    end
    else
    begin
      if (frames_seen != 1)
        report_mismatch($sformatf("%0d tx frames before read_rdy, expected 1", frames_seen));
      shown_data = read_data;
      if (cur_mode == MODE_SILENT)
      begin
        if (read_err !== 1'b1)
          report_mismatch("read_err is low after a silent responder");
        if (read_data !== 8'h00)
          report_mismatch($sformatf("read_data is %02h after a timeout", read_data));
        if (cyc - frame_end_cyc < RESP_TIMEOUT_BITS * BAUD_DIV)
          report_mismatch($sformatf("timeout came %0d cycles after the command frame",
                                    cyc - frame_end_cyc));
      end
      else if (cur_mode == MODE_BAD_PARITY)
      begin
        if (read_err !== 1'b1)
          report_mismatch("read_err is low after a response with bad parity");
      end
      else
      begin
        if (read_err !== 1'b0)
          report_mismatch("read_err is high after a good response");
        if (read_data !== model[cur_cmd[14:8]])
          report_mismatch($sformatf("read_data is %02h, expected %02h",
                                    read_data, model[cur_cmd[14:8]]));
      end
      close_row();
    end
  endtask

  // the handshake is taken at the rising edge, the same edge the DUT accepts on.
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      cyc++;
      if (cmd_vld && cmd_rdy)
      begin
        if (row_busy)
          report_problem("a command was accepted before the previous one finished");
        row_busy    = 1'b1;
        row_ok      = 1'b1;
        cur_cmd     = cmd_in;
        cur_mode    = resp_mode;
        frames_seen = 0;
      end
    end
  end

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (!reset_seen)
      begin
        if (tx !== 1'b1)
          report_mismatch("tx is not high after reset");
        if (cmd_rdy !== 1'b1)
          report_mismatch("cmd_rdy is not high after reset");
        reset_seen = 1'b1;
      end
      if (read_rdy === 1'b1)
        check_read();
    end
  end

  initial
  begin
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
        decode_frame();
    end
  end

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset is released on a falling edge, away from the edge the design samples on.
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* hw/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  input  logic  rx,
  output logic  tx,
  output logic  cmd_rdy,
  output logic  read_rdy,
  output logic  read_err,
  output byte_t read_data
);

  logic  timer_restart;
  logic  timer_half;
  logic  bit_tick;
  logic  tx_load;
  byte_t tx_byte;
  logic  tx_done;
  logic  rx_begin;
  logic  line_low;
  logic  rx_done;
  logic  rx_bad;
  byte_t rx_byte;

  uart_ctrl_fsm i_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .bit_tick      (bit_tick),
    .tx_done       (tx_done),
    .line_low      (line_low),
    .rx_done       (rx_done),
    .rx_bad        (rx_bad),
    .rx_byte       (rx_byte),
    .cmd_rdy       (cmd_rdy),
    .timer_restart (timer_restart),
    .timer_half    (timer_half),
    .tx_load       (tx_load),
    .tx_byte       (tx_byte),
    .rx_begin      (rx_begin),
    .read_rdy      (read_rdy),
    .read_err      (read_err),
    .read_data     (read_data)
  );

  // one timer paces both directions, since tx and rx never overlap.
  baud_timer i_timer (
    .clk           (clk),
    .rst_n         (rst_n),
    .timer_restart (timer_restart),
    .timer_half    (timer_half),
    .bit_tick      (bit_tick)
  );

  uart_tx_shift i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_load  (tx_load),
    .bit_tick (bit_tick),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_shift i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_begin (rx_begin),
    .bit_tick (bit_tick),
    .line_low (line_low),
    .rx_done  (rx_done),
    .rx_bad   (rx_bad),
    .rx_byte  (rx_byte)
  );

endmodule

/* hw/uart_ctrl_fsm.sv */
`timescale 1ns/1ps

module uart_ctrl_fsm
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  cmd_t  cmd_in,
  input  logic  cmd_vld,
  input  logic  bit_tick,
  input  logic  tx_done,
  input  logic  line_low,
  input  logic  rx_done,
  input  logic  rx_bad,
  input  byte_t rx_byte,
  output logic  cmd_rdy,
  output logic  timer_restart,
  output logic  timer_half,
  output logic  tx_load,
  output byte_t tx_byte,
  output logic  rx_begin,
  output logic  read_rdy,
  output logic  read_err,
  output byte_t read_data
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  cmd_t        cmd_q;
  logic [5:0]  wait_cnt;
  logic        gap_end;
  logic        timeout;

  assign gap_end = (state == WR_GAP) && bit_tick && (wait_cnt == 6'(GAP_BITS - 1));
  assign timeout = (state == RD_WAIT_START) && !line_low && bit_tick &&
                   (wait_cnt == 6'(RESP_TIMEOUT_BITS - 1));

  always_comb
  begin
    state_nxt     = state;
    timer_restart = 1'b0;
    timer_half    = 1'b0;
    tx_load       = 1'b0;
    rx_begin      = 1'b0;
    unique case (state)
      IDLE:
      begin
        if (cmd_vld)
        begin
          state_nxt = JUDGE;
        end
      end
      JUDGE:
      begin
        tx_load       = 1'b1;
        timer_restart = 1'b1;
        state_nxt     = cmd_q[15] ? WR_ADDR_FRAME : RD_CMD_FRAME;
      end
      WR_ADDR_FRAME:
      begin
        if (tx_done)
        begin
          state_nxt = WR_GAP;
        end
      end
      WR_GAP:
      begin
        // the timer has just reloaded on this tick, so the data frame stays aligned.
        if (gap_end)
        begin
          tx_load   = 1'b1;
          state_nxt = WR_DATA_FRAME;
        end
      end
      WR_DATA_FRAME:
      begin
        if (tx_done)
        begin
          state_nxt = IDLE;
        end
      end
      RD_CMD_FRAME:
      begin
        if (tx_done)
        begin
          state_nxt = RD_WAIT_START;
        end
      end
      RD_WAIT_START:
      begin
        if (line_low)
        begin
          timer_restart = 1'b1;
          timer_half    = 1'b1;
          rx_begin      = 1'b1;
          state_nxt     = RD_DATA_FRAME;
        end
        else if (timeout)
        begin
          state_nxt = RD_DONE;
        end
      end
      RD_DATA_FRAME:
      begin
        if (rx_done)
        begin
          state_nxt = RD_DONE;
        end
      end
      RD_DONE:
      begin
        state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      wait_cnt <= '0;
      read_err <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      // the wait counter restarts on every state change.
      if (state_nxt != state)
      begin
        wait_cnt <= '0;
      end
      else if (bit_tick && ((state == WR_GAP) || (state == RD_WAIT_START)))
      begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      if (timeout)
      begin
        read_err <= 1'b1;
      end
      else if ((state == RD_DATA_FRAME) && rx_done)
      begin
        read_err <= rx_bad;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_q <= cmd_in;
    end
    if (timeout)
    begin
      read_data <= '0;
    end
    else if ((state == RD_DATA_FRAME) && rx_done)
    begin
      read_data <= rx_byte;
    end
  end

  assign cmd_rdy  = (state == IDLE);
  assign read_rdy = (state == RD_DONE);
  assign tx_byte  = (state == WR_GAP) ? cmd_q[7:0] : cmd_q[15:8];

endmodule

/* hw/uart_rx_shift.sv */
`timescale 1ns/1ps

module uart_rx_shift
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  input  logic  rx_begin,
  input  logic  bit_tick,
  output logic  line_low,
  output logic  rx_done,
  output logic  rx_bad,
  output byte_t rx_byte
);

  logic       rx_meta;
  logic       rx_sync;
  logic       active;
  logic [3:0] smp_cnt;
  logic       frame_err;
  logic       par_acc;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign line_low = ~rx_sync;

  // sample 0 is the start bit, 1 to 8 are data, 9 is parity and 10 is the stop bit.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active    <= 1'b0;
      smp_cnt   <= '0;
      frame_err <= 1'b0;
      par_acc   <= 1'b0;
    end
    else if (rx_begin)
    begin
      active    <= 1'b1;
      smp_cnt   <= '0;
      frame_err <= 1'b0;
      par_acc   <= 1'b0;
    end
    else if (active && bit_tick)
    begin
      smp_cnt <= smp_cnt + 1'b1;
      if (smp_cnt == 4'd0)
      begin
        frame_err <= rx_sync;
      end
      else if (smp_cnt <= 4'd9)
      begin
        par_acc <= par_acc ^ rx_sync;
      end
      else
      begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (active && bit_tick && (smp_cnt >= 4'd1) && (smp_cnt <= 4'd8))
    begin
      rx_byte <= {rx_sync, rx_byte[7:1]};
    end
  end

  assign rx_done = active && bit_tick && (smp_cnt == 4'd10);

  // odd parity over data plus parity bit is an error, as is a low stop bit.
  assign rx_bad = frame_err | par_acc | ~rx_sync;

endmodule

/* hw/uart_tx_shift.sv */
`timescale 1ns/1ps

module uart_tx_shift
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  tx_load,
  input  logic  bit_tick,
  input  byte_t tx_byte,
  output logic  tx,
  output logic  tx_done
);

  logic [10:0] frame;
  logic [3:0]  bit_cnt;
  logic        busy;

  // frame[0] is the bit on the line, so the start bit shows right after the load.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame   <= '1;
      bit_cnt <= '0;
      busy    <= 1'b0;
    end
    else if (tx_load)
    begin
      frame   <= {1'b1, ^tx_byte, tx_byte, 1'b0};
      bit_cnt <= '0;
      busy    <= 1'b1;
    end
    else if (busy && bit_tick)
    begin
      frame <= {1'b1, frame[10:1]};
      if (bit_cnt == 4'd10)
      begin
        busy <= 1'b0;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign tx = frame[0];

  // the eleventh tick closes the stop bit.
  assign tx_done = busy && bit_tick && (bit_cnt == 4'd10);

endmodule

/* hw/baud_timer.sv */
`timescale 1ns/1ps

module baud_timer
  import uart_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic timer_restart,
  input  logic timer_half,
  output logic bit_tick
);

  baud_cnt_t cnt;

  // the counter runs freely; a restart realigns it to a new bit edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= baud_cnt_t'(BAUD_DIV - 1);
    end
    else if (timer_restart)
    begin
      cnt <= timer_half ? baud_cnt_t'(HALF_DIV - 1) : baud_cnt_t'(BAUD_DIV - 1);
    end
    else if (cnt == '0)
    begin
      cnt <= baud_cnt_t'(BAUD_DIV - 1);
    end
    else
    begin
      cnt <= cnt - 1'b1;
    end
  end

  assign bit_tick = (cnt == '0);

endmodule

/* hw/uart_pkg.sv */
package uart_pkg;

  // clock cycles per serial bit.
  localparam int BAUD_DIV = 434;

  // offset from the start-bit edge to the middle of the bit.
  localparam int HALF_DIV = BAUD_DIV / 2;

  // bit times to wait for the start bit of a read response.
  localparam int RESP_TIMEOUT_BITS = 32;

  // idle bit times between the address frame and the data frame of a write.
  localparam int GAP_BITS = 1;

  typedef logic [15:0] cmd_t;
  typedef logic [7:0]  byte_t;
  typedef logic [8:0]  baud_cnt_t;

  typedef enum logic [3:0] {
    IDLE,
    JUDGE,
    WR_ADDR_FRAME,
    WR_GAP,
    WR_DATA_FRAME,
    RD_CMD_FRAME,
    RD_WAIT_START,
    RD_DATA_FRAME,
    RD_DONE
  } ctrl_state_t;

endpackage
